//--- Bender.yml
package:
  name: dga

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/dga_pkg.sv
      - logic/cs_decode.sv
      - logic/cycle_reg.sv
      - logic/ctrl_strobe_reg.sv
      - logic/dga_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/clk_gen.sv
      - test/dga_tb.sv

//--- all.f
+incdir+logic
logic/dga_pkg.sv
logic/cs_decode.sv
logic/cycle_reg.sv
logic/ctrl_strobe_reg.sv
logic/dga_top.sv
test/clk_gen.sv
test/dga_tb.sv

//--- logic/cs_decode.sv
/*
 * Combinational decode of the strobed control-store command.
 * Produces memory/I/O requests and control strobes for the register stages
 */

`timescale 1ns/10ps

`include "dga_consts.svh"

module cs_decode (
  input  logic               lcs,
  input  dga_pkg::cs_word_t  cmd,
  output dga_pkg::mem_req_t  mem_req,
  output dga_pkg::ctrl_req_t ctrl_req
);

  logic mem_group;

  // Top bit of the command field splits the two groups
  assign mem_group = cmd.comm[`DGA_COMM_W-1];

  // Memory and I/O group
  always_comb begin
    mem_req = '0;
    if (lcs && mem_group) begin
      case (cmd.comm)
        `CMD_FETCH,
        `CMD_READ,
        `CMD_WRITE,
        `CMD_FMISS: begin
          mem_req.mreq  = 1'b1;
          mem_req.fetch = (cmd.comm == `CMD_FETCH);
          mem_req.write = (cmd.comm == `CMD_WRITE);
          mem_req.fmiss = (cmd.comm == `CMD_FMISS);
          // Byte format for every memory cycle
          mem_req.form  = cmd.mis[0];
        end
        `CMD_IORQ: begin
          mem_req.iorq     = 1'b1;
          mem_req.short_io = cmd.mis[1];
        end
        `CMD_RWCS: begin
          mem_req.rwcs = 1'b1;
        end
        default: begin
          mem_req = '0;
        end
      endcase
    end
  end

  // Control group
  always_comb begin
    ctrl_req = '0;
    if (lcs && !mem_group) begin
      case (cmd.comm)
        `CMD_WCHIM: begin
          // Channel image write only with an empty modifier
          ctrl_req.wchim = (cmd.mis == '0);
        end
        `CMD_SIOC: begin
          ctrl_req.sioc = 1'b1;
        end
        `CMD_SSTOP: begin
          ctrl_req.sstop = 1'b1;
        end
        `CMD_SLOW: begin
          ctrl_req.slow = 1'b1;
        end
        `CMD_START: begin
          ctrl_req.start = 1'b1;
        end
        `CMD_CLRTI: begin
          ctrl_req.clrti = 1'b1;
        end
        default: begin
          ctrl_req = '0;
        end
      endcase
    end
  end

endmodule

//--- logic/ctrl_strobe_reg.sv
/*
 * Registers the one-cycle control strobes and holds the two system
 * control bits, loaded from the data bus on system I/O control
 */

`timescale 1ns/10ps

`include "dga_consts.svh"

module ctrl_strobe_reg (
  input  logic                  clk,
  input  logic                  rst,
  input  dga_pkg::ctrl_req_t    ctrl_req,
  input  logic [`DGA_IDB_W-1:0] idb,
  output logic                  sstop,
  output logic                  start,
  output logic                  clrti,
  output logic                  sioc,
  output logic                  slow,
  output logic                  wchim,
  output logic                  emcl,
  output logic                  sys_reset
);

  dga_pkg::ctrl_req_t strobe_q;
  logic               emcl_q;
  logic               sys_reset_q;

  // Strobes live for exactly one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      strobe_q <= '0;
    end else begin
      strobe_q <= ctrl_req;
    end
  end

  // System control bits hold until the next sioc command
  always_ff @(posedge clk) begin
    if (rst) begin
      emcl_q      <= 1'b0;
      sys_reset_q <= 1'b0;
    end else if (ctrl_req.sioc) begin
      emcl_q      <= idb[`DGA_IDB_EMCL_BIT];
      sys_reset_q <= idb[`DGA_IDB_RESET_BIT];
    end
  end

  assign sstop     = strobe_q.sstop;
  assign start     = strobe_q.start;
  assign clrti     = strobe_q.clrti;
  assign sioc      = strobe_q.sioc;
  assign slow      = strobe_q.slow;
  assign wchim     = strobe_q.wchim;
  assign emcl      = emcl_q;
  assign sys_reset = sys_reset_q;

endmodule

//--- logic/cycle_reg.sv
/*
 * Registers the memory-cycle and I/O requests for one cycle.
 * Read and data transfer phases are formed ahead of the flops
 */

`timescale 1ns/10ps

module cycle_reg (
  input  logic              clk,
  input  logic              rst,
  input  dga_pkg::mem_req_t mem_req,
  output logic              mreq,
  output logic              fetch,
  output logic              write,
  output logic              fmiss,
  output logic              form,
  output logic              iorq,
  output logic              short_io,
  output logic              rwcs,
  output logic              rt,
  output logic              dt
);

  dga_pkg::mem_req_t req_q;
  logic              rt_d;
  logic              dt_d;
  logic              rt_q;
  logic              dt_q;

  // Transfer phases, so they line up with mreq
  assign rt_d = mem_req.mreq & ~mem_req.write;
  assign dt_d = mem_req.mreq & mem_req.write;

  always_ff @(posedge clk) begin
    if (rst) begin
      req_q <= '0;
      rt_q  <= 1'b0;
      dt_q  <= 1'b0;
    end else begin
      req_q <= mem_req;
      rt_q  <= rt_d;
      dt_q  <= dt_d;
    end
  end

  assign mreq     = req_q.mreq;
  assign fetch    = req_q.fetch;
  assign write    = req_q.write;
  assign fmiss    = req_q.fmiss;
  assign form     = req_q.form;
  assign iorq     = req_q.iorq;
  assign short_io = req_q.short_io;
  assign rwcs     = req_q.rwcs;
  assign rt       = rt_q;
  assign dt       = dt_q;

endmodule

//--- logic/dga_consts.svh
/*
 * Field widths, data bus bit positions and command codes of the decode
 * gate array. Included by the package, the RTL that decodes or loads bits
 */

`ifndef DGA_CONSTS_SVH
`define DGA_CONSTS_SVH

// Control-store command word fields
`define DGA_COMM_W 5
`define DGA_MIS_W  2

// Internal data bus
`define DGA_IDB_W  16

// Data bus bits taken on a system I/O control command
`define DGA_IDB_EMCL_BIT  5
`define DGA_IDB_RESET_BIT 7

// Memory and I/O group, top bit of comm set
`define CMD_FETCH 5'h10
`define CMD_READ  5'h11
`define CMD_WRITE 5'h12
`define CMD_FMISS 5'h13
`define CMD_IORQ  5'h18
`define CMD_RWCS  5'h19

// Control group, top bit of comm clear
`define CMD_WCHIM 5'h01
`define CMD_SIOC  5'h05
`define CMD_SSTOP 5'h06
`define CMD_SLOW  5'h08
`define CMD_START 5'h0B
`define CMD_CLRTI 5'h0D

// Codes not listed here decode to nothing
// 1Fh and the gaps in both groups are spare

`endif

//--- logic/dga_pkg.sv
/*
 * Types shared by the decoder and the two register stages.
 * Referenced by scoped name from each module that needs them
 */

`include "dga_consts.svh"

package dga_pkg;

  // Command word as strobed from the control store
  typedef struct packed {
    logic [`DGA_MIS_W-1:0]  mis;
    logic [`DGA_COMM_W-1:0] comm;
  } cs_word_t;

  // Memory-cycle and I/O requests
  typedef struct packed {
    logic mreq;
    logic fetch;
    logic write;
    logic fmiss;
    // Byte format, taken from mis[0]
    logic form;
    logic iorq;
    // Short I/O, taken from mis[1]
    logic short_io;
    logic rwcs;
  } mem_req_t;

  // One-shot control strobes
  typedef struct packed {
    logic sstop;
    logic start;
    logic clrti;
    // Also the load enable for emcl and sys_reset
    logic sioc;
    logic slow;
    logic wchim;
  } ctrl_req_t;

endpackage

//--- logic/dga_top.sv
/*
 * Decode gate array top: command decoder feeding the request
 * register and the control strobe register
 */

`timescale 1ns/10ps

`include "dga_consts.svh"

module dga_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  lcs,
  input  dga_pkg::cs_word_t     cmd,
  input  logic [`DGA_IDB_W-1:0] idb,
  output logic                  mreq,
  output logic                  fetch,
  output logic                  write,
  output logic                  fmiss,
  output logic                  form,
  output logic                  iorq,
  output logic                  short_io,
  output logic                  rwcs,
  output logic                  rt,
  output logic                  dt,
  output logic                  sstop,
  output logic                  start,
  output logic                  clrti,
  output logic                  sioc,
  output logic                  slow,
  output logic                  wchim,
  output logic                  emcl,
  output logic                  sys_reset
);

  dga_pkg::mem_req_t  mem_req;
  dga_pkg::ctrl_req_t ctrl_req;

  cs_decode i_cs_decode (
    .lcs      (lcs),
    .cmd      (cmd),
    .mem_req  (mem_req),
    .ctrl_req (ctrl_req)
  );

  cycle_reg i_cycle_reg (
    .clk      (clk),
    .rst      (rst),
    .mem_req  (mem_req),
    .mreq     (mreq),
    .fetch    (fetch),
    .write    (write),
    .fmiss    (fmiss),
    .form     (form),
    .iorq     (iorq),
    .short_io (short_io),
    .rwcs     (rwcs),
    .rt       (rt),
    .dt       (dt)
  );

  ctrl_strobe_reg i_ctrl_strobe_reg (
    .clk       (clk),
    .rst       (rst),
    .ctrl_req  (ctrl_req),
    .idb       (idb),
    .sstop     (sstop),
    .start     (start),
    .clrti     (clrti),
    .sioc      (sioc),
    .slow      (slow),
    .wchim     (wchim),
    .emcl      (emcl),
    .sys_reset (sys_reset)
  );

endmodule

//--- test/clk_gen.sv
/*
 * Free-running testbench clock with a 20 ns period.
 * Instantiated once by the testbench top
 */

`timescale 1ns/10ps

module clk_gen (
  output logic clk
);

  localparam real half_period = 10.0;

  initial begin
    clk = 1'b0;
  end

  // Toggle every half period
  always begin
    #(half_period) clk = ~clk;
  end

endmodule

//--- test/dga_tb.sv
/*
 * Table-driven testbench for the decode gate array. One table row is
 * applied per clock, and its expected outputs are checked one cycle later
 */

`timescale 1ns/10ps

`include "dga_consts.svh"

module dga_tb;

  // Every DUT output, in the order the table lists them
  typedef struct packed {
    dga_pkg::mem_req_t  mem;
    logic               rt;
    logic               dt;
    dga_pkg::ctrl_req_t ctrl;
    logic               emcl;
    logic               sys_reset;
  } dga_out_t;

  typedef struct packed {
    logic                  lcs;
    dga_pkg::cs_word_t     cmd;
    logic [`DGA_IDB_W-1:0] idb;
    dga_out_t              exp;
  } stim_row_t;

  logic                  clk;
  logic                  rst;
  logic                  lcs;
  dga_pkg::cs_word_t     cmd;
  logic [`DGA_IDB_W-1:0] idb;
  logic                  mreq;
  logic                  fetch;
  logic                  write;
  logic                  fmiss;
  logic                  form;
  logic                  iorq;
  logic                  short_io;
  logic                  rwcs;
  logic                  rt;
  logic                  dt;
  logic                  sstop;
  logic                  start;
  logic                  clrti;
  logic                  sioc;
  logic                  slow;
  logic                  wchim;
  logic                  emcl;
  logic                  sys_reset;

  stim_row_t rows[$];
  int        errors;
  int        checks;
  int        cycle_count;
  int        cycle_limit;

  clk_gen i_clk_gen (
    .clk (clk)
  );

  dga_top i_dga_top (.*);

  // mem_exp bits: mreq fetch write fmiss form iorq short_io rwcs
  // ctrl_exp bits: sstop start clrti sioc slow wchim
  task automatic add_row(
    input logic                   lcs_val,
    input logic [`DGA_MIS_W-1:0]  mis_val,
    input logic [`DGA_COMM_W-1:0] comm_val,
    input logic [`DGA_IDB_W-1:0]  idb_val,
    input logic [7:0]             mem_exp,
    input logic                   rt_exp,
    input logic                   dt_exp,
    input logic [5:0]             ctrl_exp,
    input logic                   emcl_exp,
    input logic                   sys_reset_exp
  );
    stim_row_t row;
    row.lcs           = lcs_val;
    row.cmd.mis       = mis_val;
    row.cmd.comm      = comm_val;
    row.idb           = idb_val;
    row.exp.mem       = mem_exp;
    row.exp.rt        = rt_exp;
    row.exp.dt        = dt_exp;
    row.exp.ctrl      = ctrl_exp;
    row.exp.emcl      = emcl_exp;
    row.exp.sys_reset = sys_reset_exp;
    rows.push_back(row);
  endtask

  task automatic fill_table();
    // Memory cycles, byte format from mis[0]
    add_row(1, 2'd0, `CMD_FETCH, 16'h0000, 8'b1100_0000, 1, 0, 6'b000000, 0, 0);
    add_row(1, 2'd1, `CMD_FETCH, 16'h0000, 8'b1100_1000, 1, 0, 6'b000000, 0, 0);
    add_row(1, 2'd0, `CMD_READ,  16'h0000, 8'b1000_0000, 1, 0, 6'b000000, 0, 0);
    add_row(1, 2'd1, `CMD_READ,  16'h0000, 8'b1000_1000, 1, 0, 6'b000000, 0, 0);
    add_row(1, 2'd0, `CMD_WRITE, 16'h0000, 8'b1010_0000, 0, 1, 6'b000000, 0, 0);
    add_row(1, 2'd1, `CMD_WRITE, 16'h0000, 8'b1010_1000, 0, 1, 6'b000000, 0, 0);
    add_row(1, 2'd0, `CMD_FMISS, 16'h0000, 8'b1001_0000, 1, 0, 6'b000000, 0, 0);
    add_row(1, 2'd1, `CMD_FMISS, 16'h0000, 8'b1001_1000, 1, 0, 6'b000000, 0, 0);
    add_row(1, 2'd2, `CMD_READ,  16'h0000, 8'b1000_0000, 1, 0, 6'b000000, 0, 0);
    add_row(1, 2'd3, `CMD_WRITE, 16'h0000, 8'b1010_1000, 0, 1, 6'b000000, 0, 0);
    // I/O, short I/O from mis[1]
    add_row(1, 2'd0, `CMD_IORQ,  16'h0000, 8'b0000_0100, 0, 0, 6'b000000, 0, 0);
    add_row(1, 2'd2, `CMD_IORQ,  16'h0000, 8'b0000_0110, 0, 0, 6'b000000, 0, 0);
    add_row(1, 2'd1, `CMD_IORQ,  16'h0000, 8'b0000_0100, 0, 0, 6'b000000, 0, 0);
    add_row(1, 2'd3, `CMD_IORQ,  16'h0000, 8'b0000_0110, 0, 0, 6'b000000, 0, 0);
    add_row(1, 2'd0, `CMD_RWCS,  16'h0000, 8'b0000_0001, 0, 0, 6'b000000, 0, 0);
    add_row(1, 2'd3, `CMD_RWCS,  16'h0000, 8'b0000_0001, 0, 0, 6'b000000, 0, 0);
    // Control strobes, wchim only with mis zero
    add_row(1, 2'd0, `CMD_SSTOP, 16'h0000, 8'b0000_0000, 0, 0, 6'b100000, 0, 0);
    add_row(1, 2'd0, `CMD_START, 16'h0000, 8'b0000_0000, 0, 0, 6'b010000, 0, 0);
    add_row(1, 2'd0, `CMD_CLRTI, 16'h0000, 8'b0000_0000, 0, 0, 6'b001000, 0, 0);
    add_row(1, 2'd0, `CMD_SLOW,  16'h0000, 8'b0000_0000, 0, 0, 6'b000010, 0, 0);
    add_row(1, 2'd0, `CMD_WCHIM, 16'h0000, 8'b0000_0000, 0, 0, 6'b000001, 0, 0);
    add_row(1, 2'd1, `CMD_WCHIM, 16'h0000, 8'b0000_0000, 0, 0, 6'b000000, 0, 0);
    add_row(1, 2'd2, `CMD_WCHIM, 16'h0000, 8'b0000_0000, 0, 0, 6'b000000, 0, 0);
    add_row(1, 2'd3, `CMD_WCHIM, 16'h0000, 8'b0000_0000, 0, 0, 6'b000000, 0, 0);
    add_row(1, 2'd0, `CMD_SSTOP, 16'h0000, 8'b0000_0000, 0, 0, 6'b100000, 0, 0);
    add_row(0, 2'd0, `CMD_SSTOP, 16'h0000, 8'b0000_0000, 0, 0, 6'b000000, 0, 0);
    // System control bits, bit 5 to emcl and bit 7 to sys_reset
    add_row(1, 2'd0, `CMD_SIOC,  16'h0000, 8'b0000_0000, 0, 0, 6'b000100, 0, 0);
    add_row(1, 2'd0, `CMD_SIOC,  16'h0020, 8'b0000_0000, 0, 0, 6'b000100, 1, 0);
    add_row(1, 2'd0, `CMD_FETCH, 16'h00A0, 8'b1100_0000, 1, 0, 6'b000000, 1, 0);
    add_row(1, 2'd0, `CMD_SIOC,  16'h0080, 8'b0000_0000, 0, 0, 6'b000100, 0, 1);
    add_row(0, 2'd0, `CMD_SIOC,  16'hFFFF, 8'b0000_0000, 0, 0, 6'b000000, 0, 1);
    add_row(1, 2'd0, `CMD_SIOC,  16'h00A0, 8'b0000_0000, 0, 0, 6'b000100, 1, 1);
    add_row(1, 2'd0, `CMD_START, 16'h0000, 8'b0000_0000, 0, 0, 6'b010000, 1, 1);
    add_row(1, 2'd0, `CMD_SIOC,  16'hFF5F, 8'b0000_0000, 0, 0, 6'b000100, 0, 0);
    add_row(1, 2'd0, `CMD_SIOC,  16'h00A0, 8'b0000_0000, 0, 0, 6'b000100, 1, 1);
    // Idle strobe and spare codes
    add_row(0, 2'd0, `CMD_READ,  16'h0000, 8'b0000_0000, 0, 0, 6'b000000, 1, 1);
    add_row(0, 2'd1, `CMD_WRITE, 16'h0000, 8'b0000_0000, 0, 0, 6'b000000, 1, 1);
    add_row(1, 2'd3, 5'h1F,      16'h0000, 8'b0000_0000, 0, 0, 6'b000000, 1, 1);
    add_row(1, 2'd0, 5'h14,      16'h0000, 8'b0000_0000, 0, 0, 6'b000000, 1, 1);
    add_row(1, 2'd0, 5'h00,      16'h0000, 8'b0000_0000, 0, 0, 6'b000000, 1, 1);
    add_row(1, 2'd1, 5'h1A,      16'h0000, 8'b0000_0000, 0, 0, 6'b000000, 1, 1);
  endtask

  task automatic compare_bit(input string tag, input string name,
                             input logic expected, input logic actual);
    checks++;
    assert (actual === expected)
      else begin
        errors++;
        $display("Error at %0t ns (%s): %s expected %b, actual %b",
                 $time, tag, name, expected, actual);
      end
  endtask

  task automatic check_outputs(input dga_out_t exp, input string tag);
    compare_bit(tag, "mreq", exp.mem.mreq, mreq);
    compare_bit(tag, "fetch", exp.mem.fetch, fetch);
    compare_bit(tag, "write", exp.mem.write, write);
    compare_bit(tag, "fmiss", exp.mem.fmiss, fmiss);
    compare_bit(tag, "form", exp.mem.form, form);
    compare_bit(tag, "iorq", exp.mem.iorq, iorq);
    compare_bit(tag, "short_io", exp.mem.short_io, short_io);
    compare_bit(tag, "rwcs", exp.mem.rwcs, rwcs);
    compare_bit(tag, "rt", exp.rt, rt);
    compare_bit(tag, "dt", exp.dt, dt);
    compare_bit(tag, "sstop", exp.ctrl.sstop, sstop);
    compare_bit(tag, "start", exp.ctrl.start, start);
    compare_bit(tag, "clrti", exp.ctrl.clrti, clrti);
    compare_bit(tag, "sioc", exp.ctrl.sioc, sioc);
    compare_bit(tag, "slow", exp.ctrl.slow, slow);
    compare_bit(tag, "wchim", exp.ctrl.wchim, wchim);
    compare_bit(tag, "emcl", exp.emcl, emcl);
    compare_bit(tag, "sys_reset", exp.sys_reset, sys_reset);
  endtask

  // Watchdog sized from the reset length and the table
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Run timed out after %0d cycles before the table was done", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    rst         = 1'b1;
    lcs         = 1'b0;
    cmd         = '0;
    idb         = '0;
    errors      = 0;
    checks      = 0;
    cycle_count = 0;
    fill_table();
    cycle_limit = 16 + rows.size() + 20;

    // Reset, with a live sioc held on the inputs for part of it
    for (int c = 1; c <= 16; c++) begin
      @(posedge clk);
      if (c == 4) begin
        lcs      <= 1'b1;
        cmd.mis  <= '0;
        cmd.comm <= `CMD_SIOC;
        idb      <= 16'hFFFF;
      end
      if (c == 12) begin
        lcs <= 1'b0;
        cmd <= '0;
        idb <= '0;
      end
      if (c == 16) begin
        rst <= 1'b0;
      end
      @(negedge clk);
      check_outputs('0, "reset");
    end

    // One row per edge, each checked in the following cycle
    for (int i = 0; i <= rows.size(); i++) begin
      @(posedge clk);
      if (i < rows.size()) begin
        lcs <= rows[i].lcs;
        cmd <= rows[i].cmd;
        idb <= rows[i].idb;
      end else begin
        lcs <= 1'b0;
        cmd <= '0;
        idb <= '0;
      end
      @(negedge clk);
      if (i == 0) begin
        check_outputs('0, "after reset");
      end else begin
        check_outputs(rows[i-1].exp, $sformatf("row %0d", i - 1));
      end
    end

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
